// ==== fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// pc loaded on reset
`define FETCH_RESET_PC 32'h0000_0000

// byte address of rom word 0
`define ROM_BASE 32'h0000_0000

// rom size in 32-bit words
`define ROM_WORDS 32

// upper bound of random wait states,
// applied separately to the address and the data phase
`define MAX_WAIT 3

`endif

// ==== fetch_pkg.sv ====
package fetch_pkg;

	// byte address on the fetch bus
	typedef logic [31:0] addr_t;

	// one instruction word
	typedef logic [31:0] inst_t;

	// axi read response codes, only the two the rom can return
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	// fetch fsm
	typedef enum logic [1:0] {
		WAIT_ADDR   = 2'b00,
		WAIT_DATA   = 2'b01,
		WAIT_DECODE = 2'b10
	} fetch_state_t;

endpackage

// ==== axi_rd_if.sv ====
`timescale 1ns/100ps

interface axi_rd_if;
	import fetch_pkg::*;

	// read address channel
	addr_t araddr;
	logic  arvalid;
	logic  arready;

	// read data channel
	inst_t rdata;
	resp_t rresp;
	logic  rvalid;
	logic  rready;

	// fetch side
	modport manager (
		output araddr,
		output arvalid,
		output rready,
		input  arready,
		input  rdata,
		input  rresp,
		input  rvalid
	);

	// memory side
	modport subordinate (
		input  araddr,
		input  arvalid,
		input  rready,
		output arready,
		output rdata,
		output rresp,
		output rvalid
	);

endinterface

// ==== fetch_unit.sv ====
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_unit (
	input  logic             clk,
	input  logic             rst,
	input  logic             flush,
	input  fetch_pkg::addr_t flush_target,
	input  logic             idu_ready,
	output logic             idu_valid,
	output fetch_pkg::inst_t idu_inst,
	output fetch_pkg::addr_t idu_pc,
	output logic             idu_fault,
	axi_rd_if.manager        bus
);
	import fetch_pkg::*;

	fetch_state_t state;
	addr_t        pc;

	// last fetched word, held for decode
	inst_t inst_q;
	logic  fault_q;

	// flush seen while the read is still on the bus
	logic  flush_pending;
	addr_t flush_pc;

	logic  fast_hit;
	logic  drop_data;
	addr_t redirect_pc;
	logic  rsp_fault;

	// address and data accepted in the same cycle
	assign fast_hit = (state == WAIT_ADDR) && bus.arready && bus.rvalid;

	assign drop_data = flush || flush_pending;

	// a flush in this cycle wins over an older latched one
	assign redirect_pc = flush ? flush_target : flush_pc;

	assign rsp_fault = (bus.rresp != RESP_OKAY);

	assign bus.araddr  = pc;
	assign bus.arvalid = (state == WAIT_ADDR);
	assign bus.rready  = (state == WAIT_DATA) || ((state == WAIT_ADDR) && bus.arready);

	// decode side
	assign idu_valid = ((state == WAIT_DECODE) || fast_hit) && !drop_data;
	assign idu_inst  = fast_hit ? bus.rdata : inst_q;
	assign idu_fault = fast_hit ? rsp_fault : fault_q;
	assign idu_pc    = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= WAIT_ADDR;
			pc            <= `FETCH_RESET_PC;
			flush_pending <= 1'b0;
		end else begin
			case (state)
				WAIT_ADDR: begin
					if (fast_hit) begin
						flush_pending <= 1'b0;
						if (drop_data) begin
							// data of this read is thrown away
							pc <= redirect_pc;
						end else if (idu_ready) begin
							pc <= pc + 32'd4;
						end else begin
							state <= WAIT_DECODE;
						end
					end else begin
						// address must stay stable, so redirect after the read
						if (flush) begin
							flush_pending <= 1'b1;
						end
						if (bus.arready) begin
							state <= WAIT_DATA;
						end
					end
				end
				WAIT_DATA: begin
					if (bus.rvalid) begin
						flush_pending <= 1'b0;
						if (drop_data) begin
							pc    <= redirect_pc;
							state <= WAIT_ADDR;
						end else begin
							state <= WAIT_DECODE;
						end
					end else if (flush) begin
						flush_pending <= 1'b1;
					end
				end
				WAIT_DECODE: begin
					if (flush) begin
						pc    <= flush_target;
						state <= WAIT_ADDR;
					end else if (idu_ready) begin
						pc    <= pc + 32'd4;
						state <= WAIT_ADDR;
					end
				end
				default: begin
					state <= WAIT_ADDR;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (flush) begin
			flush_pc <= flush_target;
		end
		if (bus.rvalid && bus.rready) begin
			inst_q  <= bus.rdata;
			fault_q <= rsp_fault;
		end
	end

endmodule

// ==== inst_rom.sv ====
`timescale 1ns/100ps
`include "fetch_settings.svh"

module inst_rom (
	input logic           clk,
	input logic           rst,
	axi_rd_if.subordinate bus
);
	import fetch_pkg::*;

	localparam int          WAIT_W    = $clog2(`MAX_WAIT + 1);
	localparam int          IDX_W     = $clog2(`ROM_WORDS);
	localparam addr_t       ROM_BYTES = addr_t'(`ROM_WORDS * 4);
	localparam logic [15:0] LFSR_SEED = 16'hace1;

	typedef enum logic {
		ROM_ADDR,
		ROM_DATA
	} rom_state_t;

	inst_t rom [`ROM_WORDS];

	rom_state_t        state;
	logic [15:0]       lfsr;
	logic [WAIT_W-1:0] wait_cnt;
	logic [WAIT_W-1:0] data_wait;
	logic [WAIT_W-1:0] pick_addr;
	logic [WAIT_W-1:0] pick_data;

	addr_t            addr_q;
	addr_t            rd_addr;
	addr_t            offset;
	logic             in_range;
	logic [IDX_W-1:0] idx;

	initial begin
		$readmemh("inst_rom.hex", rom);
	end

	// x^16 + x^14 + x^13 + x^11, free running
	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= LFSR_SEED;
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
	end

	assign pick_addr = WAIT_W'(lfsr[7:0] % (`MAX_WAIT + 1));
	assign pick_data = WAIT_W'(lfsr[15:8] % (`MAX_WAIT + 1));

	// combined path reads straight from araddr
	assign rd_addr = (state == ROM_ADDR) ? bus.araddr : addr_q;
	assign offset  = rd_addr - `ROM_BASE;

	// below the base the offset wraps high, so one compare covers both ends
	assign in_range = (offset < ROM_BYTES);
	assign idx      = offset[IDX_W+1:2];

	assign bus.rdata   = in_range ? rom[idx] : '0;
	assign bus.rresp   = in_range ? RESP_OKAY : RESP_SLVERR;
	assign bus.arready = (state == ROM_ADDR) && (wait_cnt == '0);
	assign bus.rvalid  = ((state == ROM_DATA) && (wait_cnt == '0)) ||
	                     (bus.arready && bus.arvalid && (data_wait == '0));

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ROM_ADDR;
			wait_cnt  <= '0;
			data_wait <= WAIT_W'(`MAX_WAIT);
		end else begin
			case (state)
				ROM_ADDR: begin
					if (wait_cnt != '0) begin
						if (bus.arvalid) begin
							wait_cnt <= wait_cnt - 1'b1;
						end
					end else if (bus.arvalid) begin
						if (bus.rvalid && bus.rready) begin
							wait_cnt  <= pick_addr;
							data_wait <= pick_data;
						end else begin
							// rvalid, once up, stays until taken
							// the cycle after the transfer is the first wait
							state    <= ROM_DATA;
							wait_cnt <= (data_wait == '0) ? '0 : data_wait - 1'b1;
						end
					end
				end
				ROM_DATA: begin
					if (wait_cnt != '0) begin
						wait_cnt <= wait_cnt - 1'b1;
					end else if (bus.rready) begin
						state     <= ROM_ADDR;
						wait_cnt  <= pick_addr;
						data_wait <= pick_data;
					end
				end
				default: begin
					state <= ROM_ADDR;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (bus.arvalid && bus.arready) begin
			addr_q <= bus.araddr;
		end
	end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             flush,
	input  fetch_pkg::addr_t flush_target,
	input  logic             idu_ready,
	output logic             idu_valid,
	output fetch_pkg::inst_t idu_inst,
	output fetch_pkg::addr_t idu_pc,
	output logic             idu_fault
);

	// fetch to rom read channel
	axi_rd_if bus ();

	fetch_unit u_fetch (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.flush_target (flush_target),
		.idu_ready    (idu_ready),
		.idu_valid    (idu_valid),
		.idu_inst     (idu_inst),
		.idu_pc       (idu_pc),
		.idu_fault    (idu_fault),
		.bus          (bus.manager)
	);

	inst_rom u_rom (
		.clk (clk),
		.rst (rst),
		.bus (bus.subordinate)
	);

endmodule

// ==== tb_fetch.sv ====
`timescale 1ns/100ps
`include "fetch_settings.svh"

module tb_fetch;
	import fetch_pkg::*;

	localparam int DELIVERIES   = 600;
	localparam int CYCLE_LIMIT  = DELIVERIES * (2 * `MAX_WAIT + 4) + 100;
	localparam int SETTLE_LIMIT = 4 * (2 * `MAX_WAIT + 4);

	logic  clk;
	logic  rst;
	logic  flush;
	addr_t flush_target;
	logic  idu_ready;
	logic  idu_valid;
	inst_t idu_inst;
	addr_t idu_pc;
	logic  idu_fault;

	// local copy of the program image
	inst_t rom_img [`ROM_WORDS];

	int errors    = 0;
	int delivered = 0;
	int faults    = 0;
	int cycles    = 0;

	// reference model state
	addr_t exp_pc;
	addr_t last_pc;
	logic  held;
	addr_t held_pc;
	inst_t held_inst;

	fetch_top DUT (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.flush_target (flush_target),
		.idu_ready    (idu_ready),
		.idu_valid    (idu_valid),
		.idu_inst     (idu_inst),
		.idu_pc       (idu_pc),
		.idu_fault    (idu_fault)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// {fault, instruction} expected at a given pc
	function automatic logic [32:0] expected_fetch(input addr_t pc);
		addr_t offset;
		offset = pc - `ROM_BASE;
		if (offset < `ROM_WORDS * 4) begin
			return {1'b0, rom_img[offset >> 2]};
		end
		return {1'b1, 32'h0};
	endfunction

	function automatic addr_t word_addr(input int unsigned idx);
		return `ROM_BASE + addr_t'(idx * 4);
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_run();
		$display("run ended: %0d deliveries, %0d with fault, %0d errors",
			delivered, faults, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	// one cycle of stimulus, applied on the falling edge
	task automatic drive(input logic rand_ready, input logic rand_flush);
		@(negedge clk);
		idu_ready = rand_ready ? (($urandom % 4) != 0) : 1'b1;
		if (rand_flush && (($urandom % 16) == 0)) begin
			flush        = 1'b1;
			flush_target = word_addr($urandom % `ROM_WORDS);
		end else begin
			flush = 1'b0;
		end
	endtask

	task automatic run_until(input int count, input logic rand_ready, input logic rand_flush);
		while (delivered < count) begin
			drive(rand_ready, rand_flush);
		end
	endtask

	// model update and compare on every rising edge
	always @(posedge clk) begin : compare
		logic [32:0] exp;
		if (rst) begin
			exp_pc = `FETCH_RESET_PC;
			held   = 1'b0;
		end else begin
			// a stalled instruction must not move or vanish
			if (held && !flush) begin
				check("idu_valid while stalled", idu_valid, 1'b1);
				check("idu_pc while stalled", idu_pc, held_pc);
				check("idu_inst while stalled", idu_inst, held_inst);
			end
			if (flush) begin
				check("idu_valid in flush cycle", idu_valid, 1'b0);
				exp_pc = flush_target;
				held   = 1'b0;
			end else if (idu_valid && idu_ready) begin
				exp = expected_fetch(exp_pc);
				check("idu_pc", idu_pc, exp_pc);
				check("idu_inst", idu_inst, exp[31:0]);
				check("idu_fault", idu_fault, exp[32]);
				if (idu_fault) begin
					faults++;
				end
				last_pc = idu_pc;
				delivered++;
				exp_pc = exp_pc + 32'd4;
				held   = 1'b0;
			end else if (idu_valid) begin
				held      = 1'b1;
				held_pc   = idu_pc;
				held_inst = idu_inst;
			end else begin
				held = 1'b0;
			end
		end
	end

	initial begin : watchdog
		fetch_state_t st;
		wait (rst === 1'b0);
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		st = DUT.u_fetch.state;
		errors++;
		$display("ERROR: timeout after %0d cycles with %0d of %0d deliveries, fetch state %s",
			cycles, delivered, DELIVERIES, st.name());
		end_run();
	end

	initial begin : stimulus
		int          start;
		int          faults_before;
		int          waited;
		addr_t       last_target;
		void'($urandom(32'h11e787e0));
		rst          = 1'b1;
		flush        = 1'b0;
		flush_target = '0;
		idu_ready    = 1'b0;
		$readmemh("inst_rom.hex", rom_img);
		repeat (16) @(negedge clk);
		rst = 1'b0;

		// straight line fetch, decode never stalls
		run_until(80, 1'b0, 1'b0);

		// decode back-pressure
		run_until(200, 1'b1, 1'b0);

		// random flushes inside the rom
		run_until(380, 1'b1, 1'b1);

		// redirect near the end of the rom and run off it
		@(negedge clk);
		flush         = 1'b1;
		flush_target  = word_addr(`ROM_WORDS - 3);
		idu_ready     = 1'b1;
		start         = delivered;
		faults_before = faults;
		run_until(start + 12, 1'b1, 1'b0);
		check("faulted deliveries past rom end", faults - faults_before, 32'd9);

		// flushes on consecutive cycles, the last target must win
		for (int n = 0; n < 4; n++) begin
			for (int k = 0; k < n + 2; k++) begin
				@(negedge clk);
				flush        = 1'b1;
				flush_target = word_addr($urandom % `ROM_WORDS);
				idu_ready    = $urandom % 2;
			end
			last_target = flush_target;
			start       = delivered;
			@(negedge clk);
			flush     = 1'b0;
			idu_ready = 1'b1;
			waited    = 0;
			while (delivered == start && waited < SETTLE_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			if (delivered == start) begin
				errors++;
				$display("ERROR: no delivery within %0d cycles after back-to-back flushes",
					SETTLE_LIMIT);
			end else begin
				check("pc after back-to-back flushes", last_pc, last_target);
			end
		end

		// mixed traffic up to the end
		run_until(DELIVERIES, 1'b1, 1'b1);
		@(negedge clk);
		end_run();
	end

endmodule

// ==== inst_rom.hex ====
// one 32-bit instruction word per line, rom word 0 first
// word n holds addi x1, x1, n+1
00108093
00208093
00308093
00408093
00508093
00608093
00708093
00808093
00908093
00a08093
00b08093
00c08093
00d08093
00e08093
00f08093
01008093
01108093
01208093
01308093
01408093
01508093
01608093
01708093
01808093
01908093
01a08093
01b08093
01c08093
01d08093
01e08093
01f08093
02008093

// ==== filelist.f ====
+incdir+.
fetch_pkg.sv
axi_rd_if.sv
fetch_unit.sv
inst_rom.sv
fetch_top.sv
tb_fetch.sv

// ==== Bender.yml ====
package:
  name: fetch_subsystem

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - axi_rd_if.sv
      - fetch_unit.sv
      - inst_rom.sv
      - fetch_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_fetch.sv
